// File: filelist.f
+incdir+test
logic/exec_pkg.sv
logic/exec_decode.sv
logic/exec_alu.sv
logic/mem_align.sv
logic/exec_writeback.sv
logic/exec_stage.sv
test/tb_exec_stage.sv

// File: Bender.yml
package:
  name: exec_stage

sources:
  - logic/exec_pkg.sv
  - logic/exec_decode.sv
  - logic/exec_alu.sv
  - logic/mem_align.sv
  - logic/exec_writeback.sv
  - logic/exec_stage.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_exec_stage.sv

// File: test/tb_exec_vectors.svh
task automatic fill_table();
    // Each row helper takes the instruction first and its expected results last
    // R form with op1 f000_1234 and op2 0000_0105
    alu_row(enc(7'h00, 3'd0, 5'd1, 7'h33), 32'hf000_1234, 32'h105, 1'b1, 32'hf000_1339);
    alu_row(enc(7'h20, 3'd0, 5'd2, 7'h33), 32'hf000_1234, 32'h105, 1'b1, 32'hf000_112f);
    alu_row(enc(7'h00, 3'd1, 5'd3, 7'h33), 32'hf000_1234, 32'h105, 1'b1, 32'h0002_4680);
    alu_row(enc(7'h00, 3'd2, 5'd4, 7'h33), 32'hf000_1234, 32'h105, 1'b1, 32'h0000_0001);
    alu_row(enc(7'h00, 3'd3, 5'd5, 7'h33), 32'hf000_1234, 32'h105, 1'b1, 32'h0000_0000);
    alu_row(enc(7'h00, 3'd4, 5'd6, 7'h33), 32'hf000_1234, 32'h105, 1'b1, 32'hf000_1331);
    alu_row(enc(7'h00, 3'd5, 5'd7, 7'h33), 32'hf000_1234, 32'h105, 1'b1, 32'h0780_0091);
    alu_row(enc(7'h20, 3'd5, 5'd8, 7'h33), 32'hf000_1234, 32'h105, 1'b1, 32'hff80_0091);
    alu_row(enc(7'h00, 3'd6, 5'd9, 7'h33), 32'hf000_1234, 32'h105, 1'b1, 32'hf000_1335);
    alu_row(enc(7'h00, 3'd7, 5'd10, 7'h33), 32'hf000_1234, 32'h105, 1'b1, 32'h0000_0004);
    // I form with immediate -8, whose top bits also fill func7
    alu_row(enc(7'h7f, 3'd0, 5'd11, 7'h13), 32'hf000_1234, 32'hffff_fff8, 1'b1, 32'hf000_122c);
    alu_row(enc(7'h7f, 3'd2, 5'd12, 7'h13), 32'hf000_1234, 32'hffff_fff8, 1'b1, 32'h0000_0001);
    alu_row(enc(7'h7f, 3'd3, 5'd13, 7'h13), 32'hf000_1234, 32'hffff_fff8, 1'b1, 32'h0000_0001);
    alu_row(enc(7'h7f, 3'd4, 5'd14, 7'h13), 32'hf000_1234, 32'hffff_fff8, 1'b1, 32'h0fff_edcc);
    alu_row(enc(7'h7f, 3'd6, 5'd15, 7'h13), 32'hf000_1234, 32'hffff_fff8, 1'b1, 32'hffff_fffc);
    alu_row(enc(7'h7f, 3'd7, 5'd16, 7'h13), 32'hf000_1234, 32'hffff_fff8, 1'b1, 32'hf000_1230);
    alu_row(enc(7'h00, 3'd1, 5'd17, 7'h13), 32'hf000_1234, 32'h8, 1'b1, 32'h0012_3400);
    alu_row(enc(7'h20, 3'd5, 5'd18, 7'h13), 32'hf000_1234, 32'h408, 1'b1, 32'hfff0_0012);
    alu_row(enc(7'h00, 3'd5, 5'd19, 7'h13), 32'hf000_1234, 32'h8, 1'b1, 32'h00f0_0012);
    alu_row(enc(7'h00, 3'd0, 5'd0, 7'h33), 32'hf000_1234, 32'h4, 1'b0, 32'h0);
    // Loads from the word 8a7b_c6d5
    load_row(enc(7'h00, 3'd0, 5'd20, 7'h03), 2'd0, 32'hffff_ffd5);
    load_row(enc(7'h00, 3'd0, 5'd21, 7'h03), 2'd1, 32'hffff_ffc6);
    load_row(enc(7'h00, 3'd0, 5'd22, 7'h03), 2'd2, 32'h0000_007b);
    load_row(enc(7'h00, 3'd0, 5'd23, 7'h03), 2'd3, 32'hffff_ff8a);
    load_row(enc(7'h00, 3'd4, 5'd24, 7'h03), 2'd0, 32'h0000_00d5);
    load_row(enc(7'h00, 3'd4, 5'd25, 7'h03), 2'd3, 32'h0000_008a);
    load_row(enc(7'h00, 3'd1, 5'd26, 7'h03), 2'd0, 32'hffff_c6d5);
    load_row(enc(7'h00, 3'd1, 5'd27, 7'h03), 2'd2, 32'hffff_8a7b);
    load_row(enc(7'h00, 3'd5, 5'd28, 7'h03), 2'd0, 32'h0000_c6d5);
    load_row(enc(7'h00, 3'd5, 5'd29, 7'h03), 2'd2, 32'h0000_8a7b);
    load_row(enc(7'h00, 3'd2, 5'd30, 7'h03), 2'd0, 32'h8a7b_c6d5);
    // Stores of 1122_3344 merged into 8a7b_c6d5
    store_row(enc(7'h00, 3'd0, 5'd9, 7'h23), 2'd0, 32'h8a7b_c644);
    store_row(enc(7'h00, 3'd0, 5'd9, 7'h23), 2'd1, 32'h8a7b_44d5);
    store_row(enc(7'h00, 3'd0, 5'd9, 7'h23), 2'd2, 32'h8a44_c6d5);
    store_row(enc(7'h00, 3'd0, 5'd9, 7'h23), 2'd3, 32'h447b_c6d5);
    store_row(enc(7'h00, 3'd1, 5'd9, 7'h23), 2'd0, 32'h8a7b_3344);
    store_row(enc(7'h00, 3'd1, 5'd9, 7'h23), 2'd2, 32'h3344_c6d5);
    store_row(enc(7'h00, 3'd2, 5'd9, 7'h23), 2'd0, 32'h1122_3344);
    // Branches, forward and backward
    branch_row(enc(7'h00, 3'd0, 5'd8, 7'h63), 32'h5, 32'h5, 32'h20, 1'b1);
    branch_row(enc(7'h00, 3'd0, 5'd8, 7'h63), 32'h5, 32'h6, 32'h20, 1'b0);
    branch_row(enc(7'h00, 3'd1, 5'd8, 7'h63), 32'h5, 32'h6, 32'hffff_fff0, 1'b1);
    branch_row(enc(7'h00, 3'd1, 5'd8, 7'h63), 32'h5, 32'h5, 32'h20, 1'b0);
    branch_row(enc(7'h00, 3'd4, 5'd8, 7'h63), 32'hffff_ffff, 32'h1, 32'h20, 1'b1);
    branch_row(enc(7'h00, 3'd4, 5'd8, 7'h63), 32'h1, 32'hffff_ffff, 32'h20, 1'b0);
    branch_row(enc(7'h00, 3'd5, 5'd8, 7'h63), 32'h1, 32'hffff_ffff, 32'hffff_fff0, 1'b1);
    branch_row(enc(7'h00, 3'd5, 5'd8, 7'h63), 32'hffff_ffff, 32'h1, 32'h20, 1'b0);
    branch_row(enc(7'h00, 3'd6, 5'd8, 7'h63), 32'h1, 32'hffff_ffff, 32'h20, 1'b1);
    branch_row(enc(7'h00, 3'd6, 5'd8, 7'h63), 32'hffff_ffff, 32'h1, 32'h20, 1'b0);
    branch_row(enc(7'h00, 3'd7, 5'd8, 7'h63), 32'hffff_ffff, 32'h1, 32'hffff_fff0, 1'b1);
    branch_row(enc(7'h00, 3'd7, 5'd8, 7'h63), 32'h1, 32'h1, 32'h20, 1'b1);
    branch_row(enc(7'h00, 3'd7, 5'd8, 7'h63), 32'h1, 32'hffff_ffff, 32'h20, 1'b0);
    // Unknown opcode and unknown load func3 give bubbles
    none_row(enc(7'h00, 3'd0, 5'd12, 7'h7f));
    none_row(enc(7'h00, 3'd3, 5'd13, 7'h03));
endtask

// File: test/tb_exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_stage;

    localparam int HALF_PERIOD    = 5;
    localparam int PERIOD         = 2 * HALF_PERIOD;
    localparam int RST_CYCLES     = 3;
    localparam int CYCLES_PER_ROW = 20;
    localparam logic [31:0] SEED  = 32'hf43dc42c;

    // One memory word sits at MEM_BASE and every other address returns a fill pattern
    localparam exec_pkg::word_t MEM_BASE   = 32'h0000_0100;
    localparam exec_pkg::word_t MEM_WORD   = 32'h8a7b_c6d5;
    localparam exec_pkg::word_t STORE_DATA = 32'h1122_3344;
    localparam exec_pkg::word_t INST_ADDR  = 32'h0000_0400;

    typedef struct packed {
        exec_pkg::word_t inst;
        exec_pkg::word_t iaddr;
        exec_pkg::word_t op1;
        exec_pkg::word_t op2;
        exec_pkg::word_t off;
        logic            rwen;
        exec_pkg::word_t rdata;
        logic            mwen;
        exec_pkg::word_t mdata;
        logic            jump;
    } row_t;

    logic            clk;
    logic            arst_n;
    logic            in_valid;
    logic            in_ready;
    exec_pkg::word_t inst;
    exec_pkg::word_t inst_addr;
    exec_pkg::word_t op1;
    exec_pkg::word_t op2;
    exec_pkg::word_t offset;
    exec_pkg::word_t mem_addr;
    exec_pkg::word_t mem_rdata;
    logic            out_valid;
    logic            out_ready;
    logic            reg_wen;
    logic [4:0]      reg_waddr;
    exec_pkg::word_t reg_wdata;
    logic            mem_wen;
    exec_pkg::word_t mem_waddr;
    exec_pkg::word_t mem_wdata;
    logic            jump_flag;
    exec_pkg::word_t jump_addr;

    row_t            rows[$];
    int              pend[$];
    int              acc_cyc[$];
    int              cyc = 0;
    int              taken_cnt = 0;
    logic            table_ready = 1'b0;
    logic            stalled = 1'b0;
    logic [31:0]     lfsr = SEED;

    logic            s_rwen;
    logic [4:0]      s_raddr;
    exec_pkg::word_t s_rdata;
    logic            s_mwen;
    exec_pkg::word_t s_maddr;
    exec_pkg::word_t s_mdata;
    logic            s_jump;
    exec_pkg::word_t s_jaddr;

    exec_stage u_dut (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .inst_i      (inst),
        .inst_addr_i (inst_addr),
        .op1_i       (op1),
        .op2_i       (op2),
        .offset_i    (offset),
        .mem_addr_o  (mem_addr),
        .mem_rdata_i (mem_rdata),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .reg_wen_o   (reg_wen),
        .reg_waddr_o (reg_waddr),
        .reg_wdata_o (reg_wdata),
        .mem_wen_o   (mem_wen),
        .mem_waddr_o (mem_waddr),
        .mem_wdata_o (mem_wdata),
        .jump_flag_o (jump_flag),
        .jump_addr_o (jump_addr)
    );

    assign mem_rdata = ({mem_addr[31:2], 2'b00} == MEM_BASE) ? MEM_WORD
                     : {mem_addr[15:0], mem_addr[31:16]} ^ 32'h5a5a_a5a5;

    always #(HALF_PERIOD) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic exec_pkg::word_t enc(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [6:0] opc);
        return {f7, 10'd0, f3, rd, opc};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_word(input string what, input exec_pkg::word_t got,
                              input exec_pkg::word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input string what, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic alu_row(input exec_pkg::word_t i, input exec_pkg::word_t a,
                           input exec_pkg::word_t b, input logic wen,
                           input exec_pkg::word_t res);
        row_t r;
        r = '0;
        r.inst  = i;
        r.iaddr = INST_ADDR;
        r.op1   = a;
        r.op2   = b;
        r.rwen  = wen;
        r.rdata = res;
        rows.push_back(r);
    endtask

    // Loads reach MEM_BASE + k through a positive offset from the word below
    task automatic load_row(input exec_pkg::word_t i, input logic [1:0] k,
                            input exec_pkg::word_t res);
        row_t r;
        r = '0;
        r.inst  = i;
        r.iaddr = INST_ADDR;
        r.op1   = MEM_BASE - 32'd4;
        r.off   = 32'd4 + k;
        r.rwen  = 1'b1;
        r.rdata = res;
        rows.push_back(r);
    endtask

    // Stores reach MEM_BASE + k through a negative offset from the word above
    task automatic store_row(input exec_pkg::word_t i, input logic [1:0] k,
                             input exec_pkg::word_t merged);
        row_t r;
        r = '0;
        r.inst  = i;
        r.iaddr = INST_ADDR;
        r.op1   = MEM_BASE + 32'd4;
        r.op2   = STORE_DATA;
        r.off   = 32'hffff_fffc + k;
        r.mwen  = 1'b1;
        r.mdata = merged;
        rows.push_back(r);
    endtask

    task automatic branch_row(input exec_pkg::word_t i, input exec_pkg::word_t a,
                              input exec_pkg::word_t b, input exec_pkg::word_t off,
                              input logic taken);
        row_t r;
        r = '0;
        r.inst  = i;
        r.iaddr = INST_ADDR;
        r.op1   = a;
        r.op2   = b;
        r.off   = off;
        r.jump  = taken;
        rows.push_back(r);
    endtask

    task automatic none_row(input exec_pkg::word_t i);
        row_t r;
        r = '0;
        r.inst  = i;
        r.iaddr = INST_ADDR;
        r.op1   = 32'h0000_0010;
        r.op2   = 32'h0000_0020;
        rows.push_back(r);
    endtask

    `include "tb_exec_vectors.svh"

    // Random back-pressure on the output channel
    always @(posedge clk) begin
        #1;
        lfsr      = lfsr_step(lfsr);
        out_ready = lfsr[0];
    end

    always @(negedge clk) begin : monitor
        row_t exp_row;
        if (arst_n && table_ready) begin
            if (out_valid) begin
                if (!stalled) begin
                    if (pend.size() == 0) begin
                        fail_run("A result appeared without an accepted instruction");
                    end
                    if (cyc != acc_cyc[0]) begin
                        fail_run($sformatf("Row %0d did not appear one cycle after its accept",
                                           pend[0]));
                    end
                end else begin
                    check_flag("stalled reg_wen_o", reg_wen, s_rwen);
                    check_addr("stalled reg_waddr_o", reg_waddr, s_raddr);
                    check_word("stalled reg_wdata_o", reg_wdata, s_rdata);
                    check_flag("stalled mem_wen_o", mem_wen, s_mwen);
                    check_word("stalled mem_waddr_o", mem_waddr, s_maddr);
                    check_word("stalled mem_wdata_o", mem_wdata, s_mdata);
                    check_flag("stalled jump_flag_o", jump_flag, s_jump);
                    check_word("stalled jump_addr_o", jump_addr, s_jaddr);
                end
                if (out_ready) begin
                    exp_row = rows[pend[0]];
                    check_flag("reg_wen_o", reg_wen, exp_row.rwen);
                    if (exp_row.rwen) begin
                        check_addr("reg_waddr_o", reg_waddr, exp_row.inst[11:7]);
                        check_word("reg_wdata_o", reg_wdata, exp_row.rdata);
                    end
                    check_flag("mem_wen_o", mem_wen, exp_row.mwen);
                    if (exp_row.mwen) begin
                        check_word("mem_waddr_o", mem_waddr, MEM_BASE);
                        check_word("mem_wdata_o", mem_wdata, exp_row.mdata);
                    end
                    check_flag("jump_flag_o", jump_flag, exp_row.jump);
                    if (exp_row.jump) begin
                        check_word("jump_addr_o", jump_addr, exp_row.iaddr + exp_row.off);
                    end
                    void'(pend.pop_front());
                    void'(acc_cyc.pop_front());
                    taken_cnt = taken_cnt + 1;
                    stalled   = 1'b0;
                end else begin
                    check_flag("in_ready_o under back-pressure", in_ready, 1'b0);
                    stalled = 1'b1;
                    s_rwen  = reg_wen;
                    s_raddr = reg_waddr;
                    s_rdata = reg_wdata;
                    s_mwen  = mem_wen;
                    s_maddr = mem_waddr;
                    s_mdata = mem_wdata;
                    s_jump  = jump_flag;
                    s_jaddr = jump_addr;
                end
            end else begin
                if (stalled) begin
                    fail_run("out_valid_o dropped while its result was stalled");
                end
                stalled = 1'b0;
            end
        end
    end

    initial begin
        wait (table_ready);
        #((RST_CYCLES + CYCLES_PER_ROW * rows.size()) * PERIOD);
        fail_run($sformatf("Timeout with %0d of %0d results taken", taken_cnt, rows.size()));
    end

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        inst      = '0;
        inst_addr = '0;
        op1       = '0;
        op2       = '0;
        offset    = '0;
        fill_table();
        table_ready = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_flag("out_valid_o after reset", out_valid, 1'b0);
        check_flag("reg_wen_o after reset", reg_wen, 1'b0);
        check_flag("mem_wen_o after reset", mem_wen, 1'b0);
        check_flag("jump_flag_o after reset", jump_flag, 1'b0);
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #1;
            in_valid  = 1'b1;
            inst      = rows[i].inst;
            inst_addr = rows[i].iaddr;
            op1       = rows[i].op1;
            op2       = rows[i].op2;
            offset    = rows[i].off;
            // The row is accepted on the edge after a negedge that shows ready
            do begin
                @(negedge clk);
            end while (!in_ready);
            pend.push_back(i);
            acc_cyc.push_back(cyc + 1);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        inst     = '0;
        wait (taken_cnt == rows.size());
        repeat (3) @(negedge clk);
        if (!out_valid && pend.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            fail_run("Extra result seen after the last row was taken");
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  wire                     clk_i,
    input  wire                     arst_n_i,
    input  wire                     in_valid_i,
    output logic                    in_ready_o,
    input  wire exec_pkg::word_t    inst_i,
    input  wire exec_pkg::word_t    inst_addr_i,
    input  wire exec_pkg::word_t    op1_i,
    input  wire exec_pkg::word_t    op2_i,
    input  wire exec_pkg::word_t    offset_i,
    output exec_pkg::word_t         mem_addr_o,
    input  wire exec_pkg::word_t    mem_rdata_i,
    output logic                    out_valid_o,
    input  wire                     out_ready_i,
    output logic                    reg_wen_o,
    output logic [4:0]              reg_waddr_o,
    output exec_pkg::word_t         reg_wdata_o,
    output logic                    mem_wen_o,
    output exec_pkg::word_t         mem_waddr_o,
    output exec_pkg::word_t         mem_wdata_o,
    output logic                    jump_flag_o,
    output exec_pkg::word_t         jump_addr_o
);

    exec_pkg::alu_op_e   alu_op;
    exec_pkg::res_sel_e  res_sel;
    exec_pkg::mem_size_e mem_size;
    logic                load_signed;
    logic [4:0]          rd;
    exec_pkg::word_t     alu_res;
    exec_pkg::word_t     load_data;
    exec_pkg::word_t     store_word;
    exec_pkg::word_t     branch_target;

    // Branches are PC relative
    assign branch_target = inst_addr_i + offset_i;

    exec_decode u_decode (
        .inst_i        (inst_i),
        .alu_op_o      (alu_op),
        .res_sel_o     (res_sel),
        .mem_size_o    (mem_size),
        .load_signed_o (load_signed),
        .rd_o          (rd)
    );

    exec_alu u_alu (
        .a_i   (op1_i),
        .b_i   (op2_i),
        .op_i  (alu_op),
        .res_o (alu_res)
    );

    // On stores op2 holds the rs2 value that gets merged into the read word
    mem_align u_align (
        .base_i        (op1_i),
        .offset_i      (offset_i),
        .store_data_i  (op2_i),
        .rdata_i       (mem_rdata_i),
        .size_i        (mem_size),
        .load_signed_i (load_signed),
        .addr_o        (mem_addr_o),
        .load_data_o   (load_data),
        .store_word_o  (store_word)
    );

    exec_writeback u_writeback (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .in_valid_i      (in_valid_i),
        .in_ready_o      (in_ready_o),
        .out_valid_o     (out_valid_o),
        .out_ready_i     (out_ready_i),
        .res_sel_i       (res_sel),
        .rd_i            (rd),
        .alu_res_i       (alu_res),
        .load_data_i     (load_data),
        .store_word_i    (store_word),
        .mem_addr_i      (mem_addr_o),
        .branch_target_i (branch_target),
        .branch_f3_i     (inst_i[14:12]),
        .reg_wen_o       (reg_wen_o),
        .reg_waddr_o     (reg_waddr_o),
        .reg_wdata_o     (reg_wdata_o),
        .mem_wen_o       (mem_wen_o),
        .mem_waddr_o     (mem_waddr_o),
        .mem_wdata_o     (mem_wdata_o),
        .jump_flag_o     (jump_flag_o),
        .jump_addr_o     (jump_addr_o)
    );

endmodule

`default_nettype wire

// File: logic/exec_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module exec_writeback (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire                         in_valid_i,
    output logic                        in_ready_o,
    output logic                        out_valid_o,
    input  wire                         out_ready_i,
    input  wire exec_pkg::res_sel_e     res_sel_i,
    input  wire [4:0]                   rd_i,
    input  wire exec_pkg::word_t        alu_res_i,
    input  wire exec_pkg::word_t        load_data_i,
    input  wire exec_pkg::word_t        store_word_i,
    input  wire exec_pkg::word_t        mem_addr_i,
    input  wire exec_pkg::word_t        branch_target_i,
    input  wire [2:0]                   branch_f3_i,
    output logic                        reg_wen_o,
    output logic [4:0]                  reg_waddr_o,
    output exec_pkg::word_t             reg_wdata_o,
    output logic                        mem_wen_o,
    output exec_pkg::word_t             mem_waddr_o,
    output exec_pkg::word_t             mem_wdata_o,
    output logic                        jump_flag_o,
    output exec_pkg::word_t             jump_addr_o
);

    logic            accept;
    logic            alu_zero;
    logic            taken;
    logic            reg_wen_d;
    exec_pkg::word_t reg_wdata_d;

    // The register refills on the same edge its old result is taken
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign accept     = in_valid_i && in_ready_o;
    assign alu_zero   = (alu_res_i == '0);

    always_comb begin
        case (branch_f3_i)
            exec_pkg::F3_BEQ, exec_pkg::F3_BGE, exec_pkg::F3_BGEU:  taken = alu_zero;
            exec_pkg::F3_BNE, exec_pkg::F3_BLT, exec_pkg::F3_BLTU:  taken = !alu_zero;
            default:                                                taken = 1'b0;
        endcase
    end

    // Writes to x0 are dropped here so the register file needs no special case
    assign reg_wen_d   = (res_sel_i == exec_pkg::ALU || res_sel_i == exec_pkg::LOAD)
                         && (rd_i != 5'd0);
    assign reg_wdata_d = (res_sel_i == exec_pkg::LOAD) ? load_data_i : alu_res_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_o <= 1'b0;
            reg_wen_o   <= 1'b0;
            mem_wen_o   <= 1'b0;
            jump_flag_o <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_o <= in_valid_i;
            reg_wen_o   <= in_valid_i && reg_wen_d;
            mem_wen_o   <= in_valid_i && (res_sel_i == exec_pkg::STORE);
            jump_flag_o <= in_valid_i && (res_sel_i == exec_pkg::BRANCH) && taken;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            reg_waddr_o <= rd_i;
            reg_wdata_o <= reg_wdata_d;
            mem_waddr_o <= {mem_addr_i[exec_pkg::XLEN-1:2], 2'b00};
            mem_wdata_o <= store_word_i;
            jump_addr_o <= branch_target_i;
        end
    end

    // A stalled result keeps every field until the sink takes it
    a_hold_stalled: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o
            && $stable({reg_wen_o, reg_waddr_o, reg_wdata_o, mem_wen_o, mem_waddr_o,
                        mem_wdata_o, jump_flag_o, jump_addr_o})
    );

endmodule

`default_nettype wire

// File: logic/mem_align.sv
`timescale 1ns/1ps
`default_nettype none

module mem_align (
    input  wire exec_pkg::word_t        base_i,
    input  wire exec_pkg::word_t        offset_i,
    input  wire exec_pkg::word_t        store_data_i,
    input  wire exec_pkg::word_t        rdata_i,
    input  wire exec_pkg::mem_size_e    size_i,
    input  wire                         load_signed_i,
    output exec_pkg::word_t             addr_o,
    output exec_pkg::word_t             load_data_o,
    output exec_pkg::word_t             store_word_o
);

    logic [1:0]      byte_sel;
    logic [7:0]      load_byte;
    logic [15:0]     load_half;
    logic [3:0]      byte_en;
    exec_pkg::word_t store_rep;

    assign addr_o   = base_i + offset_i;
    assign byte_sel = addr_o[1:0];

    always_comb begin
        case (byte_sel)
            2'd0:    load_byte = rdata_i[7:0];
            2'd1:    load_byte = rdata_i[15:8];
            2'd2:    load_byte = rdata_i[23:16];
            default: load_byte = rdata_i[31:24];
        endcase
    end

    assign load_half = byte_sel[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (size_i)
            exec_pkg::BYTE: load_data_o = {{24{load_signed_i & load_byte[7]}}, load_byte};
            exec_pkg::HALF: load_data_o = {{16{load_signed_i & load_half[15]}}, load_half};
            default:        load_data_o = rdata_i;
        endcase
    end

    // Store data is replicated across all lanes and the byte enables pick the target lanes
    always_comb begin
        case (size_i)
            exec_pkg::BYTE: begin
                byte_en   = 4'b0001 << byte_sel;
                store_rep = {4{store_data_i[7:0]}};
            end
            exec_pkg::HALF: begin
                byte_en   = byte_sel[1] ? 4'b1100 : 4'b0011;
                store_rep = {2{store_data_i[15:0]}};
            end
            default: begin
                byte_en   = 4'b1111;
                store_rep = store_data_i;
            end
        endcase
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            store_word_o[8*i +: 8] = byte_en[i] ? store_rep[8*i +: 8] : rdata_i[8*i +: 8];
        end
    end

    // Half accesses must sit on an even address, otherwise the lane pick above is wrong
    always_comb begin
        if (!$isunknown({size_i, addr_o})) begin
            assert final (size_i != exec_pkg::HALF || addr_o[0] == 1'b0);
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  wire exec_pkg::word_t    a_i,
    input  wire exec_pkg::word_t    b_i,
    input  wire exec_pkg::alu_op_e  op_i,
    output exec_pkg::word_t         res_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // Shift amounts only ever use the low five bits, also for the immediate forms
    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            exec_pkg::ADD:  res_o = a_i + b_i;
            exec_pkg::SUB:  res_o = a_i - b_i;
            exec_pkg::SLL:  res_o = a_i << shamt;
            exec_pkg::SLT:  res_o = {{(exec_pkg::XLEN - 1){1'b0}}, lt_signed};
            exec_pkg::SLTU: res_o = {{(exec_pkg::XLEN - 1){1'b0}}, lt_unsigned};
            exec_pkg::XOR:  res_o = a_i ^ b_i;
            exec_pkg::SRL:  res_o = a_i >> shamt;
            exec_pkg::SRA:  res_o = $unsigned($signed(a_i) >>> shamt);
            exec_pkg::OR:   res_o = a_i | b_i;
            exec_pkg::AND:  res_o = a_i & b_i;
            default:        res_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/exec_decode.sv
`timescale 1ns/1ps
`default_nettype none

module exec_decode (
    input  wire exec_pkg::word_t    inst_i,
    output exec_pkg::alu_op_e       alu_op_o,
    output exec_pkg::res_sel_e      res_sel_o,
    output exec_pkg::mem_size_e     mem_size_o,
    output logic                    load_signed_o,
    output logic [4:0]              rd_o
);

    logic [6:0] opcode;
    logic [2:0] func3;
    logic [6:0] func7;

    assign opcode = inst_i[6:0];
    assign func3  = inst_i[14:12];
    assign func7  = inst_i[31:25];
    assign rd_o   = inst_i[11:7];

    always_comb begin
        alu_op_o      = exec_pkg::ADD;
        res_sel_o     = exec_pkg::NONE;
        mem_size_o    = exec_pkg::WORD;
        load_signed_o = 1'b0;
        case (opcode)
            exec_pkg::OPC_R, exec_pkg::OPC_I: begin
                res_sel_o = exec_pkg::ALU;
                case (func3)
                    exec_pkg::F3_ADD_SUB: begin
                        // ADDI carries immediate bits in func7, so only the R form subtracts
                        if (opcode == exec_pkg::OPC_R && func7[5]) begin
                            alu_op_o = exec_pkg::SUB;
                        end
                    end
                    exec_pkg::F3_SLL:  alu_op_o = exec_pkg::SLL;
                    exec_pkg::F3_SLT:  alu_op_o = exec_pkg::SLT;
                    exec_pkg::F3_SLTU: alu_op_o = exec_pkg::SLTU;
                    exec_pkg::F3_XOR:  alu_op_o = exec_pkg::XOR;
                    exec_pkg::F3_SRL_SRA: begin
                        if (func7[5]) begin
                            alu_op_o = exec_pkg::SRA;
                        end else begin
                            alu_op_o = exec_pkg::SRL;
                        end
                    end
                    exec_pkg::F3_OR:   alu_op_o = exec_pkg::OR;
                    exec_pkg::F3_AND:  alu_op_o = exec_pkg::AND;
                    default:           res_sel_o = exec_pkg::NONE;
                endcase
            end
            exec_pkg::OPC_LOAD: begin
                res_sel_o = exec_pkg::LOAD;
                case (func3)
                    exec_pkg::F3_LB: begin
                        mem_size_o    = exec_pkg::BYTE;
                        load_signed_o = 1'b1;
                    end
                    exec_pkg::F3_LH: begin
                        mem_size_o    = exec_pkg::HALF;
                        load_signed_o = 1'b1;
                    end
                    exec_pkg::F3_LW:  mem_size_o = exec_pkg::WORD;
                    exec_pkg::F3_LBU: mem_size_o = exec_pkg::BYTE;
                    exec_pkg::F3_LHU: mem_size_o = exec_pkg::HALF;
                    default:          res_sel_o  = exec_pkg::NONE;
                endcase
            end
            exec_pkg::OPC_STORE: begin
                res_sel_o = exec_pkg::STORE;
                case (func3)
                    exec_pkg::F3_SB: mem_size_o = exec_pkg::BYTE;
                    exec_pkg::F3_SH: mem_size_o = exec_pkg::HALF;
                    exec_pkg::F3_SW: mem_size_o = exec_pkg::WORD;
                    default:         res_sel_o  = exec_pkg::NONE;
                endcase
            end
            exec_pkg::OPC_BRANCH: begin
                res_sel_o = exec_pkg::BRANCH;
                // Equality tests on the difference, ordering on the set-less-than flag
                case (func3)
                    exec_pkg::F3_BEQ, exec_pkg::F3_BNE:   alu_op_o  = exec_pkg::SUB;
                    exec_pkg::F3_BLT, exec_pkg::F3_BGE:   alu_op_o  = exec_pkg::SLT;
                    exec_pkg::F3_BLTU, exec_pkg::F3_BGEU: alu_op_o  = exec_pkg::SLTU;
                    default:                              res_sel_o = exec_pkg::NONE;
                endcase
            end
            default: begin
                res_sel_o = exec_pkg::NONE;
            end
        endcase
    end

    // A fully known instruction word must never leave the result class undefined
    always_comb begin
        if (!$isunknown(inst_i)) begin
            assert final (!$isunknown(res_sel_o));
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int unsigned XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    // Major opcodes of the instruction classes the stage executes
    localparam logic [6:0] OPC_R      = 7'b0110011;
    localparam logic [6:0] OPC_I      = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Register and immediate ALU forms share these func3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_LB      = 3'b000;
    localparam logic [2:0] F3_LH      = 3'b001;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_LBU     = 3'b100;
    localparam logic [2:0] F3_LHU     = 3'b101;

    localparam logic [2:0] F3_SB      = 3'b000;
    localparam logic [2:0] F3_SH      = 3'b001;
    localparam logic [2:0] F3_SW      = 3'b010;

    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    typedef enum logic [3:0] {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND} alu_op_e;

    typedef enum logic [2:0] {NONE, ALU, LOAD, STORE, BRANCH} res_sel_e;

    typedef enum logic [1:0] {BYTE, HALF, WORD} mem_size_e;

endpackage

`default_nettype wire
